/* design/pager_defs.svh */
`ifndef PAGER_DEFS_SVH
`define PAGER_DEFS_SVH

// --------------------------------------------------
// Page map geometry
// --------------------------------------------------

// Page and frame number width
`define PG_PAGE_BITS    10

// In-page offset width
`define PG_OFFSET_BITS  10

// Full virtual or physical address
`define PG_ADDR_BITS    (`PG_PAGE_BITS + `PG_OFFSET_BITS)

// One table entry per page
`define PG_PAGE_COUNT   (1 << `PG_PAGE_BITS)

`endif

/* design/pager_pkg.sv */
`include "pager_defs.svh"

package pager_pkg;

    // --------------------------------------------------
    // Address pieces
    // --------------------------------------------------
    typedef logic [`PG_PAGE_BITS-1:0]   pg_page_t;    // Virtual page or physical frame
    typedef logic [`PG_OFFSET_BITS-1:0] pg_offset_t;  // Offset inside a page

    typedef struct packed {
        pg_page_t   page;                             // Upper bits
        pg_offset_t offset;                           // Lower bits, never translated
    } pg_addr_t;

    // Per-page status, bit 0 used and bit 1 dirty
    typedef struct packed {
        logic dirty;                                  // Page written since last clear
        logic used;                                   // Page referenced since last clear
    } pg_status_t;

    // --------------------------------------------------
    // Command opcodes
    // --------------------------------------------------
    typedef enum logic [2:0] {
        PG_TRANSLATE_RD = 3'd0,                       // Translate, mark used
        PG_TRANSLATE_WR = 3'd1,                       // Translate, mark used and dirty
        PG_MAP_WRITE    = 3'd2,                       // Frame from data[9:0]
        PG_MAP_READ     = 3'd3,                       // Frame in low bits of response
        PG_STATUS_WRITE = 3'd4,                       // Used, dirty, reprio from data[2:0]
        PG_STATUS_READ  = 3'd5,                       // Same three bits back
        PG_FILL_REPRIO  = 3'd6,                       // Set reprio from start page to end
        PG_SET_MODE     = 3'd7                        // No-paging from data[0]
    } pg_op_e;

endpackage

/* design/pager_table_if.sv */
`timescale 1ns/1ps

// One synchronous port into a page-indexed table
interface pager_table_if #(
    parameter type T = logic                // Entry payload
) ();
    import pager_pkg::*;

    pg_page_t addr;                         // Entry select
    logic     we;                           // Write strobe
    T         wdata;                        // Entry to store
    T         rdata;                        // Registered entry

    // Side that issues accesses
    modport client (
        output addr,
        output we,
        output wdata,
        input  rdata
    );

    // Side that holds the storage
    modport store (
        input  addr,
        input  we,
        input  wdata,
        output rdata
    );

endinterface

/* design/pager_table.sv */
`timescale 1ns/1ps
`include "pager_defs.svh"

// Single-port page table with registered read
module pager_table #(
    parameter type T     = logic,             // Entry payload
    parameter int  DEPTH = `PG_PAGE_COUNT     // Entries
) (
    input  logic          clk,
    pager_table_if.store  tbl
);

    // --------------------------------------------------
    // Storage
    // --------------------------------------------------
    T mem [DEPTH];                            // Entries undefined until written

    always_ff @(posedge clk) begin
        if (tbl.we) begin
            mem[tbl.addr] <= tbl.wdata;       // Write lands at the edge
        end
        tbl.rdata <= mem[tbl.addr];           // Old value on a same-cycle write
    end

endmodule

/* design/pager_reprio_fill.sv */
`timescale 1ns/1ps
`include "pager_defs.svh"

// Reprioritize bit table with a background fill sequencer
module pager_reprio_fill (
    input  logic                clk,
    input  logic                reset,
    input  logic                i_start,        // Begin fill
    input  pager_pkg::pg_page_t i_start_page,   // First page to set
    input  pager_pkg::pg_page_t i_page,         // Single-page access
    input  logic                i_wr,
    input  logic                i_wdata,
    output logic                o_rdata,
    output logic                o_busy,         // Fill owns the table
    output logic                o_done          // With the last write
);
    import pager_pkg::*;

    pg_page_t fill_cnt;                         // Page being written

    pager_table_if #(.T(logic)) rp_if ();

    pager_table #(
        .T     (logic),
        .DEPTH (`PG_PAGE_COUNT)
    ) u_reprio_table (
        .clk (clk),
        .tbl (rp_if.store)
    );

    // --------------------------------------------------
    // Fill sequencer
    // --------------------------------------------------
    assign o_done = o_busy && (fill_cnt == pg_page_t'(`PG_PAGE_COUNT - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            o_busy   <= 1'b0;
            fill_cnt <= '0;
        end else if (i_start) begin
            o_busy   <= 1'b1;
            fill_cnt <= i_start_page;           // Starts writing next cycle
        end else if (o_busy) begin
            if (o_done) begin
                o_busy <= 1'b0;                 // Last page written
            end else begin
                fill_cnt <= fill_cnt + 1'b1;    // One page per cycle
            end
        end
    end

    // Port arbitration, fill wins while running
    always_comb begin
        if (o_busy) begin
            rp_if.addr  = fill_cnt;
            rp_if.we    = 1'b1;
            rp_if.wdata = 1'b1;
        end else begin
            rp_if.addr  = i_page;               // Controller access
            rp_if.we    = i_wr;
            rp_if.wdata = i_wdata;
        end
    end

    assign o_rdata = rp_if.rdata;

endmodule

/* design/pager_ctrl.sv */
`timescale 1ns/1ps
`include "pager_defs.svh"

// Command FSM for translation and table access
module pager_ctrl (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      i_cmd_valid,
    input  pager_pkg::pg_op_e         i_cmd_op,
    input  pager_pkg::pg_addr_t       i_cmd_addr,
    input  logic [`PG_ADDR_BITS-1:0]  i_cmd_data,
    input  logic                      i_rsp_ready,
    input  logic                      i_reprio_rdata,  // Registered reprio bit
    input  logic                      i_fill_busy,
    input  logic                      i_fill_done,
    pager_table_if.client             map_if,          // Frame table
    pager_table_if.client             stat_if,         // Used and dirty table
    output logic                      o_cmd_ready,
    output logic                      o_rsp_valid,
    output pager_pkg::pg_addr_t       o_rsp_data,
    output logic                      o_fill_start,
    output pager_pkg::pg_page_t       o_fill_page,
    output pager_pkg::pg_page_t       o_reprio_page,
    output logic                      o_reprio_wr,
    output logic                      o_reprio_wdata
);
    import pager_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,                                    // Waiting for a command
        ST_READ,                                    // Tables see the address
        ST_RESP,                                    // Read data back, form response
        ST_FILL                                     // Reprio fill running
    } state_e;

    state_e                   state;
    pg_op_e                   cmd_op;               // Latched command
    pg_addr_t                 cmd_addr;
    logic [`PG_ADDR_BITS-1:0] cmd_data;
    logic                     no_paging;            // Mode register
    logic                     accept;
    logic                     is_xlate;
    pg_page_t                 frame;
    pg_status_t               old_stat;
    pg_status_t               new_stat;
    pg_addr_t                 rsp_next;

    // --------------------------------------------------
    // Handshake and command latch
    // --------------------------------------------------
    assign o_cmd_ready = (state == ST_IDLE) && !o_rsp_valid && !i_fill_busy;
    assign accept      = i_cmd_valid && o_cmd_ready;
    assign is_xlate    = (cmd_op == PG_TRANSLATE_RD) || (cmd_op == PG_TRANSLATE_WR);

    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_op   <= i_cmd_op;
            cmd_addr <= i_cmd_addr;
            cmd_data <= i_cmd_data;
        end
    end

    // Fill starts on the accepting edge
    assign o_fill_start = accept && (i_cmd_op == PG_FILL_REPRIO);
    assign o_fill_page  = i_cmd_addr.page;

    // --------------------------------------------------
    // FSM
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= ST_IDLE;
            o_rsp_valid <= 1'b0;
            no_paging   <= 1'b0;
        end else begin
            if (o_rsp_valid && i_rsp_ready) begin
                o_rsp_valid <= 1'b0;                // Response taken
            end
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        state <= (i_cmd_op == PG_FILL_REPRIO) ? ST_FILL : ST_READ;
                    end
                end
                ST_READ: begin
                    state <= ST_RESP;
                    if (cmd_op == PG_SET_MODE) begin
                        no_paging <= cmd_data[0];
                    end
                end
                ST_RESP: begin
                    state       <= ST_IDLE;
                    o_rsp_valid <= 1'b1;            // Two edges after accept
                end
                ST_FILL: begin
                    if (i_fill_done || !i_fill_busy) begin
                        state       <= ST_IDLE;
                        o_rsp_valid <= 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // --------------------------------------------------
    // Response forming
    // --------------------------------------------------
    assign frame    = no_paging ? cmd_addr.page : map_if.rdata;  // Bypass map in no-paging
    assign old_stat = stat_if.rdata;

    always_comb begin
        case (cmd_op)
            PG_TRANSLATE_RD,
            PG_TRANSLATE_WR: rsp_next = {frame, cmd_addr.offset};
            PG_MAP_READ:     rsp_next = {{`PG_OFFSET_BITS{1'b0}}, map_if.rdata};
            PG_STATUS_READ:  rsp_next = {{(`PG_ADDR_BITS - 3){1'b0}}, i_reprio_rdata,
                                         old_stat.dirty, old_stat.used};
            default:         rsp_next = '0;         // Writes, mode
        endcase
    end

    // Held while the consumer stalls
    always_ff @(posedge clk) begin
        if (state == ST_RESP) begin
            o_rsp_data <= rsp_next;
        end else if (state == ST_FILL) begin
            o_rsp_data <= '0;
        end
    end

    // --------------------------------------------------
    // Table accesses
    // --------------------------------------------------
    assign map_if.addr  = cmd_addr.page;            // Always the virtual page
    assign map_if.we    = (state == ST_READ) && (cmd_op == PG_MAP_WRITE);
    assign map_if.wdata = cmd_data[`PG_PAGE_BITS-1:0];

    // Used and dirty RMW in the response cycle
    always_comb begin
        new_stat.used  = 1'b1;
        new_stat.dirty = old_stat.dirty | (cmd_op == PG_TRANSLATE_WR);
    end

    assign stat_if.addr  = cmd_addr.page;
    assign stat_if.we    = ((state == ST_READ) && (cmd_op == PG_STATUS_WRITE))
                        || ((state == ST_RESP) && is_xlate);
    assign stat_if.wdata = (state == ST_RESP)
                         ? new_stat
                         : pg_status_t'{dirty: cmd_data[1], used: cmd_data[0]};

    // Reprio single-page path
    assign o_reprio_page  = cmd_addr.page;
    assign o_reprio_wr    = (state == ST_READ) && (cmd_op == PG_STATUS_WRITE);
    assign o_reprio_wdata = cmd_data[2];

endmodule

/* design/pager_top.sv */
`timescale 1ns/1ps
`include "pager_defs.svh"

// Page management unit
module pager_top (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      i_cmd_valid,
    input  pager_pkg::pg_op_e         i_cmd_op,
    input  pager_pkg::pg_addr_t       i_cmd_addr,     // Page field picks the entry
    input  logic [`PG_ADDR_BITS-1:0]  i_cmd_data,
    output logic                      o_cmd_ready,
    output logic                      o_rsp_valid,
    output pager_pkg::pg_addr_t       o_rsp_data,
    input  logic                      i_rsp_ready
);
    import pager_pkg::*;

    // --------------------------------------------------
    // Internal wiring
    // --------------------------------------------------
    logic     reprio_rdata;
    logic     fill_busy;
    logic     fill_done;
    logic     fill_start;
    pg_page_t fill_page;
    pg_page_t reprio_page;
    logic     reprio_wr;
    logic     reprio_wdata;

    pager_table_if #(.T(pg_page_t))   map_if ();   // Frame per virtual page
    pager_table_if #(.T(pg_status_t)) stat_if ();  // Used and dirty per page

    // --------------------------------------------------
    // Instances
    // --------------------------------------------------
    pager_ctrl u_ctrl (
        .clk            (clk),
        .reset          (reset),
        .i_cmd_valid    (i_cmd_valid),
        .i_cmd_op       (i_cmd_op),
        .i_cmd_addr     (i_cmd_addr),
        .i_cmd_data     (i_cmd_data),
        .i_rsp_ready    (i_rsp_ready),
        .i_reprio_rdata (reprio_rdata),
        .i_fill_busy    (fill_busy),
        .i_fill_done    (fill_done),
        .map_if         (map_if.client),
        .stat_if        (stat_if.client),
        .o_cmd_ready    (o_cmd_ready),
        .o_rsp_valid    (o_rsp_valid),
        .o_rsp_data     (o_rsp_data),
        .o_fill_start   (fill_start),
        .o_fill_page    (fill_page),
        .o_reprio_page  (reprio_page),
        .o_reprio_wr    (reprio_wr),
        .o_reprio_wdata (reprio_wdata)
    );

    pager_table #(
        .T     (pg_page_t),
        .DEPTH (`PG_PAGE_COUNT)
    ) u_map_table (
        .clk (clk),
        .tbl (map_if.store)
    );

    pager_table #(
        .T     (pg_status_t),
        .DEPTH (`PG_PAGE_COUNT)
    ) u_stat_table (
        .clk (clk),
        .tbl (stat_if.store)
    );

    pager_reprio_fill u_reprio_fill (
        .clk          (clk),
        .reset        (reset),
        .i_start      (fill_start),
        .i_start_page (fill_page),
        .i_page       (reprio_page),
        .i_wr         (reprio_wr),
        .i_wdata      (reprio_wdata),
        .o_rdata      (reprio_rdata),
        .o_busy       (fill_busy),
        .o_done       (fill_done)
    );

endmodule

/* verification/pager_tb.sv */
`timescale 1ns/1ps
`include "pager_defs.svh"

module pager_tb;
    import pager_pkg::*;

    localparam int WAIT_LIMIT = 2000;                   // Cycles, longer than a full fill

    logic                     clk;
    logic                     reset;
    logic                     i_cmd_valid;
    pg_op_e                   i_cmd_op;
    pg_addr_t                 i_cmd_addr;
    logic [`PG_ADDR_BITS-1:0] i_cmd_data;
    logic                     o_cmd_ready;
    logic                     o_rsp_valid;
    pg_addr_t                 o_rsp_data;
    logic                     i_rsp_ready;

    int       errors;
    int       checks;
    int       tests;
    bit       aborted;                                  // A wait ran out of time
    pg_page_t frame_sb [`PG_PAGE_COUNT];                // Expected frame per page
    pg_page_t mapped_pages [$];                         // Pages with a known frame

    pager_top u_pager_top (
        .clk         (clk),
        .reset       (reset),
        .i_cmd_valid (i_cmd_valid),
        .i_cmd_op    (i_cmd_op),
        .i_cmd_addr  (i_cmd_addr),
        .i_cmd_data  (i_cmd_data),
        .o_cmd_ready (o_cmd_ready),
        .o_rsp_valid (o_rsp_valid),
        .o_rsp_data  (o_rsp_data),
        .i_rsp_ready (i_rsp_ready)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;                              // 20 ns period

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (!aborted) begin
            checks++;
            if (got !== exp) begin
                errors++;
                $display("FAILED at %0t ns: %s, got %0h expected %0h", $time, msg, got, exp);
            end
        end
    endtask

    function automatic pg_addr_t make_addr(input pg_page_t page, input pg_offset_t offset);
        pg_addr_t a;
        a.page   = page;
        a.offset = offset;
        return a;
    endfunction

    // Reprio in bit 2, dirty in bit 1, used in bit 0
    function automatic logic [31:0] status_word(input logic reprio, input logic dirty,
                                                input logic used);
        return {29'b0, reprio, dirty, used};
    endfunction

    // Both handshakes; called and left 1 ns after a rising edge
    task automatic run_cmd(input pg_op_e op, input pg_addr_t addr, input logic [19:0] data,
                           input int hold, output pg_addr_t rsp, output int lat);
        int       waited;
        pg_addr_t first;
        rsp = '0;
        lat = 0;
        if (aborted) return;
        i_cmd_valid = 1'b1;
        i_cmd_op    = op;
        i_cmd_addr  = addr;
        i_cmd_data  = data;
        i_rsp_ready = (hold == 0);                      // Stall the response if asked
        waited = 0;
        while (!o_cmd_ready && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!o_cmd_ready) begin
            $display("Timeout: the command port never became ready for %s", op.name());
            aborted     = 1'b1;
            i_cmd_valid = 1'b0;
            return;
        end
        @(posedge clk);                                 // Accepting edge
        #1;
        i_cmd_valid = 1'b0;
        waited = 0;
        while (!o_rsp_valid && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!o_rsp_valid) begin
            $display("Timeout: no response arrived for %s", op.name());
            aborted = 1'b1;
            return;
        end
        lat   = waited;
        first = o_rsp_data;
        if (op != PG_FILL_REPRIO) begin
            check(lat, 2, "response latency");          // Read cycle plus respond cycle
        end
        repeat (hold) begin
            @(posedge clk);
            #1;
            check(o_rsp_valid, 1, "valid held under back-pressure");
            check(o_rsp_data, first, "data held under back-pressure");
            check(o_cmd_ready, 0, "no accept while a response waits");
        end
        i_rsp_ready = 1'b1;
        @(posedge clk);                                 // Response taken here
        #1;
        check(o_rsp_valid, 0, "valid drops after handshake");
        rsp = first;
    endtask

    task automatic send(input pg_op_e op, input pg_addr_t addr, input logic [19:0] data,
                        output pg_addr_t rsp);
        int lat;
        run_cmd(op, addr, data, 0, rsp, lat);
    endtask

    task automatic write_map(input pg_page_t page, input pg_page_t frame);
        pg_addr_t rsp;
        send(PG_MAP_WRITE, make_addr(page, '0), {10'b0, frame}, rsp);
        check(rsp, 0, "map write response");
    endtask

    task automatic write_status(input pg_page_t page, input logic reprio, input logic dirty,
                                input logic used);
        pg_addr_t rsp;
        send(PG_STATUS_WRITE, make_addr(page, '0), {17'b0, reprio, dirty, used}, rsp);
        check(rsp, 0, "status write response");
    endtask

    task automatic set_mode(input logic no_paging);
        pg_addr_t rsp;
        send(PG_SET_MODE, make_addr('0, '0), {19'b0, no_paging}, rsp);
        check(rsp, 0, "mode write response");
    endtask

    task automatic report_test(input string name, input int start_errors);
        tests++;
        $display("%s finished with %0d error(s)", name, errors - start_errors);
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------
    task automatic basic_translation();
        pg_addr_t rsp;
        int       start;
        start = errors;
        write_map(10'd5, 10'h2A3);
        write_status(10'd5, 1'b0, 1'b0, 1'b0);          // Clean page
        send(PG_MAP_READ, make_addr(10'd5, '0), '0, rsp);
        check(rsp, 32'h2A3, "map read back");
        send(PG_TRANSLATE_RD, make_addr(10'd5, 10'h155), '0, rsp);
        check(rsp, {10'h2A3, 10'h155}, "read translation");
        send(PG_STATUS_READ, make_addr(10'd5, '0), '0, rsp);
        check(rsp, status_word(1'b0, 1'b0, 1'b1), "used set, dirty clear");
        report_test("basic_translation", start);
    endtask

    task automatic write_translation();
        pg_addr_t rsp;
        int       start;
        start = errors;
        write_map(10'd9, 10'h011);
        write_status(10'd9, 1'b1, 1'b0, 1'b0);          // Reprio left at 1
        send(PG_TRANSLATE_WR, make_addr(10'd9, 10'h3C0), '0, rsp);
        check(rsp, {10'h011, 10'h3C0}, "write translation");
        send(PG_STATUS_READ, make_addr(10'd9, '0), '0, rsp);
        check(rsp, status_word(1'b1, 1'b1, 1'b1), "dirty set, reprio kept");
        report_test("write_translation", start);
    endtask

    task automatic no_paging_mode();
        pg_addr_t rsp;
        int       start;
        start = errors;
        write_map(10'd12, 10'h3FF);                     // Mapping differs from identity
        write_status(10'd12, 1'b0, 1'b0, 1'b0);
        set_mode(1'b1);
        send(PG_TRANSLATE_RD, make_addr(10'd12, 10'h0AB), '0, rsp);
        check(rsp, {10'd12, 10'h0AB}, "no-paging passes address through");
        send(PG_STATUS_READ, make_addr(10'd12, '0), '0, rsp);
        check(rsp, status_word(1'b0, 1'b0, 1'b1), "virtual page marked used");
        set_mode(1'b0);
        send(PG_TRANSLATE_RD, make_addr(10'd12, 10'h0AB), '0, rsp);
        check(rsp, {10'h3FF, 10'h0AB}, "mapping restored");
        report_test("no_paging_mode", start);
    endtask

    task automatic reprio_fill();
        pg_addr_t rsp;
        int       lat;
        int       p;
        int       start;
        start = errors;
        for (p = 1019; p <= 1023; p++) begin
            write_status(pg_page_t'(p), 1'b0, 1'b0, 1'b0);
        end
        run_cmd(PG_FILL_REPRIO, make_addr(10'd1020, '0), '0, 0, rsp, lat);
        check(lat, `PG_PAGE_COUNT - 1020, "fill latency");
        check(rsp, 0, "fill response");
        send(PG_STATUS_READ, make_addr(10'd1019, '0), '0, rsp);
        check(rsp, status_word(1'b0, 1'b0, 1'b0), "page below start untouched");
        for (p = 1020; p <= 1023; p++) begin
            send(PG_STATUS_READ, make_addr(pg_page_t'(p), '0), '0, rsp);
            check(rsp, status_word(1'b1, 1'b0, 1'b0), "reprio set by fill");
        end
        report_test("reprio_fill", start);
    endtask

    task automatic back_pressure();
        pg_addr_t rsp;
        int       lat;
        int       hold;
        int       start;
        start = errors;
        hold  = $urandom_range(8, 3);                   // Several stalled cycles
        write_map(10'd77, 10'h155);
        run_cmd(PG_MAP_READ, make_addr(10'd77, '0), '0, hold, rsp, lat);
        check(rsp, 32'h155, "map read after stall");
        check(o_cmd_ready, 1, "ready again after handshake");
        report_test("back_pressure", start);
    endtask

    task automatic random_map_translate();
        pg_addr_t   rsp;
        pg_page_t   page;
        pg_page_t   frame;
        pg_offset_t off;
        pg_op_e     op;
        int         i;
        int         start;
        start = errors;
        mapped_pages.delete();
        for (i = 0; i < 12; i++) begin
            page  = pg_page_t'($urandom_range(`PG_PAGE_COUNT - 1, 0));
            frame = pg_page_t'($urandom_range(`PG_PAGE_COUNT - 1, 0));
            write_map(page, frame);
            frame_sb[page] = frame;                     // Latest write wins
            mapped_pages.push_back(page);
        end
        for (i = 0; i < 24; i++) begin
            page = mapped_pages[$urandom_range(mapped_pages.size() - 1, 0)];
            off  = pg_offset_t'($urandom);
            op   = ($urandom_range(1, 0) == 1) ? PG_TRANSLATE_WR : PG_TRANSLATE_RD;
            send(op, make_addr(page, off), '0, rsp);
            check(rsp, {frame_sb[page], off}, "random translation");
        end
        report_test("random_map_translate", start);
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        int seed_init;
        seed_init   = $urandom(704);                    // Fixed seed for the run
        errors      = 0;
        checks      = 0;
        tests       = 0;
        aborted     = 1'b0;
        reset       = 1'b1;
        i_cmd_valid = 1'b0;
        i_cmd_op    = PG_TRANSLATE_RD;
        i_cmd_addr  = '0;
        i_cmd_data  = '0;
        i_rsp_ready = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        check(o_rsp_valid, 0, "no response after reset");
        check(o_cmd_ready, 1, "ready right after reset");
        basic_translation();
        if (!aborted) write_translation();
        if (!aborted) no_paging_mode();
        if (!aborted) reprio_fill();
        if (!aborted) back_pressure();
        if (!aborted) random_map_translate();
        $display("Tests run: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0 && !aborted) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+design
design/pager_pkg.sv
design/pager_table_if.sv
design/pager_table.sv
design/pager_reprio_fill.sv
design/pager_ctrl.sv
design/pager_top.sv
verification/pager_tb.sv

/* Bender.yml */
package:
  name: pager

sources:
  - include_dirs:
      - design
    files:
      - design/pager_pkg.sv
      - design/pager_table_if.sv
      - design/pager_table.sv
      - design/pager_reprio_fill.sv
      - design/pager_ctrl.sv
      - design/pager_top.sv
      - target: test
        files:
          - verification/pager_tb.sv
